//--- mem_subsys.f
design/mem_pkg.sv
design/reset_stretch.sv
design/bank_decoder.sv
design/mem_bank.sv
design/read_mux.sv
design/mem_subsys_top.sv
sim/mem_subsys_tb.sv

//--- Bender.yml
package:
  name: mem_subsys

sources:
  # package first, then the RTL in dependency order
  - files:
      - design/mem_pkg.sv
      - design/reset_stretch.sv
      - design/bank_decoder.sv
      - design/mem_bank.sv
      - design/read_mux.sv
      - design/mem_subsys_top.sv

  - target: test
    files:
      - sim/mem_subsys_tb.sv

//--- sim/mem_subsys_tb.sv
`timescale 1ns/1ps

module mem_subsys_tb;

    localparam int READY_TIMEOUT = 64;
    localparam int SHADOW_WORDS  = mem_pkg::NUM_BANKS * mem_pkg::BANK_WORDS;
    localparam mem_pkg::addr_t IN_RANGE_MASK = mem_pkg::addr_t'((1 << mem_pkg::OOB_LSB) - 1);

    logic           clk = 1'b0;
    logic           rst;
    logic           ready;
    logic           req;
    mem_pkg::addr_t addr;
    logic           we;
    mem_pkg::strb_t be;
    mem_pkg::data_t wdata;
    mem_pkg::data_t rdata;
    logic           rvalid;
    logic           err;

    // reference model, one word per in-range address
    mem_pkg::data_t shadow [SHADOW_WORDS];
    logic           exp_ready;
    logic           exp_rvalid;
    logic           exp_err;
    mem_pkg::data_t exp_rdata;

    integer seed;
    int     errors;
    int     timeouts;
    bit     got_ready;

    mem_subsys_top dut_i (
        .clk    (clk),
        .rst    (rst),
        .ready  (ready),
        .req    (req),
        .addr   (addr),
        .we     (we),
        .be     (be),
        .wdata  (wdata),
        .rdata  (rdata),
        .rvalid (rvalid),
        .err    (err)
    );

    always #2 clk = ~clk;

    // any bit above the bank number puts the address out of range
    function automatic bit in_range(mem_pkg::addr_t a);
        return (a >> mem_pkg::OOB_LSB) == 0;
    endfunction

    // bank and word bits together give a flat word number
    function automatic int flat_index(mem_pkg::addr_t a);
        return int'(a[mem_pkg::OOB_LSB-1:mem_pkg::WORD_LSB]);
    endfunction

    function automatic mem_pkg::addr_t make_addr(int bank, int word);
        return mem_pkg::addr_t'((bank * mem_pkg::BANK_WORDS + word) << mem_pkg::WORD_LSB);
    endfunction

    function automatic mem_pkg::data_t merge_bytes(mem_pkg::data_t old_word,
                                                   mem_pkg::data_t new_word,
                                                   mem_pkg::strb_t lanes);
        mem_pkg::data_t res;
        res = old_word;
        for (int b = 0; b < mem_pkg::STRB_W; b++) begin
            if (lanes[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic report_mismatch(string name, mem_pkg::data_t expected,
                                   mem_pkg::data_t actual);
        errors++;
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic issue(logic write_en, mem_pkg::addr_t a, mem_pkg::strb_t lanes,
                         mem_pkg::data_t d);
        @(posedge clk);
        #1;
        req   = 1'b1;
        we    = write_en;
        addr  = a;
        be    = lanes;
        wdata = d;
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        req = 1'b0;
    endtask

    // keeps firing requests that must be dropped until ready rises
    task automatic wait_ready(output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < READY_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            if (ready === 1'b1) begin
                ok  = 1'b1;
                req = 1'b0;
            end else begin
                req   = 1'b1;
                we    = 1'($random(seed));
                addr  = mem_pkg::addr_t'($random(seed));
                be    = '1;
                wdata = mem_pkg::data_t'($random(seed));
            end
        end
        if (!ok) begin
            timeouts++;
            $display("ready never rose within %0d cycles after reset", READY_TIMEOUT);
        end
    endtask

    // expected ready and expected response for the request sampled at this edge
    always @(posedge clk) begin : model
        int idx;
        bit hit;
        int low_edges;
        // ready rises on the edge after RST_HOLD more edges with rst low
        if (rst) begin
            low_edges = 0;
        end else if (low_edges <= mem_pkg::RST_HOLD) begin
            low_edges++;
        end
        exp_ready <= (low_edges > mem_pkg::RST_HOLD);
        if (rst || exp_ready !== 1'b1 || !req) begin
            exp_rvalid <= 1'b0;
            exp_err    <= 1'b0;
        end else begin
            hit = in_range(addr);
            idx = flat_index(addr);
            exp_rvalid <= hit && !we;
            exp_err    <= !hit;
            exp_rdata  <= hit ? shadow[idx] : '0;
            if (hit && we) begin
                shadow[idx] <= merge_bytes(shadow[idx], wdata, be);
            end
        end
    end

    // outputs are registered, so the falling edge sees them settled
    a_ready: assert property (@(negedge clk) ready === exp_ready)
        else report_mismatch("ready", exp_ready, ready);

    a_rvalid: assert property (@(negedge clk) rvalid === exp_rvalid)
        else report_mismatch("rvalid", exp_rvalid, rvalid);

    a_err: assert property (@(negedge clk) err === exp_err)
        else report_mismatch("err", exp_err, err);

    a_rdata: assert property (@(negedge clk) (exp_rvalid || exp_err) |-> rdata === exp_rdata)
        else report_mismatch("rdata", exp_rdata, rdata);

    initial begin
        mem_pkg::addr_t a;
        seed     = 32'he9f26615;
        errors   = 0;
        timeouts = 0;
        rst      = 1'b1;
        req      = 1'b0;
        addr     = '0;
        we       = 1'b0;
        be       = '0;
        wdata    = '0;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        wait_ready(got_ready);

        if (got_ready) begin
            // fill every word, each read back right after its write
            for (int i = 0; i < SHADOW_WORDS; i++) begin
                a = make_addr(i / mem_pkg::BANK_WORDS, i % mem_pkg::BANK_WORDS);
                issue(1'b1, a, '1, mem_pkg::data_t'({a, ~a}));
                issue(1'b0, a, '0, '0);
            end

            // partial byte lanes
            for (int i = 0; i < 40; i++) begin
                a = mem_pkg::addr_t'($random(seed)) & IN_RANGE_MASK;
                issue(1'b1, a, mem_pkg::strb_t'($random(seed)), mem_pkg::data_t'($random(seed)));
                issue(1'b0, a, '0, '0);
            end

            // back-to-back reads, bank changes every cycle
            for (int i = 0; i < 32; i++) begin
                a = make_addr(i % mem_pkg::NUM_BANKS, (i * 37) % mem_pkg::BANK_WORDS);
                issue(1'b0, a, '0, '0);
            end
            idle();

            // out of range reads and writes, then a readback of random words
            for (int i = 0; i < 40; i++) begin
                a = mem_pkg::addr_t'($random(seed));
                if (in_range(a)) begin
                    a[mem_pkg::ADDR_W-1] = 1'b1;
                end
                issue(1'($random(seed)), a, '1, mem_pkg::data_t'($random(seed)));
            end
            for (int i = 0; i < 40; i++) begin
                a = mem_pkg::addr_t'($random(seed)) & IN_RANGE_MASK;
                issue(1'b0, a, '0, '0);
            end

            // random mix, half of the addresses forced into range
            for (int i = 0; i < 200; i++) begin
                a = mem_pkg::addr_t'($random(seed));
                if (1'($random(seed))) begin
                    a = a & IN_RANGE_MASK;
                end
                issue(1'($random(seed)), a, mem_pkg::strb_t'($random(seed)),
                      mem_pkg::data_t'($random(seed)));
            end
        end

        // let the last response reach the checks
        idle();
        idle();
        @(negedge clk);
        #1;

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- design/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic           clk,
    input  logic           rst,
    output logic           ready,
    input  logic           req,
    input  mem_pkg::addr_t addr,
    input  logic           we,
    input  mem_pkg::strb_t be,
    input  mem_pkg::data_t wdata,
    output mem_pkg::data_t rdata,
    output logic           rvalid,
    output logic           err
);

    logic               rst_int;
    mem_pkg::mem_req_t  bank_req   [mem_pkg::NUM_BANKS];
    mem_pkg::data_t     bank_rdata [mem_pkg::NUM_BANKS];
    logic               rd_go;
    mem_pkg::bank_idx_t sel;
    logic               oob;

    reset_stretch reset_stretch_i (
        .clk     (clk),
        .rst     (rst),
        .rst_int (rst_int),
        .ready   (ready)
    );

    bank_decoder bank_decoder_i (
        .ready    (ready),
        .req      (req),
        .addr     (addr),
        .we       (we),
        .be       (be),
        .wdata    (wdata),
        .bank_req (bank_req),
        .rd_go    (rd_go),
        .sel      (sel),
        .oob      (oob)
    );

    // one bank per decoder output
    for (genvar i = 0; i < mem_pkg::NUM_BANKS; i++) begin : g_bank
        mem_bank mem_bank_i (
            .clk      (clk),
            .rst      (rst_int),
            .bank_req (bank_req[i]),
            .rdata    (bank_rdata[i])
        );
    end

    read_mux read_mux_i (
        .clk        (clk),
        .rst        (rst_int),
        .rd_go      (rd_go),
        .sel        (sel),
        .oob        (oob),
        .bank_rdata (bank_rdata),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .err        (err)
    );

endmodule

//--- design/read_mux.sv
`timescale 1ns/1ps

module read_mux (
    input  logic               clk,
    input  logic               rst,
    input  logic               rd_go,
    input  mem_pkg::bank_idx_t sel,
    input  logic               oob,
    input  mem_pkg::data_t     bank_rdata [mem_pkg::NUM_BANKS],
    output mem_pkg::data_t     rdata,
    output logic               rvalid,
    output logic               err
);

    mem_pkg::bank_idx_t sel_q;

    // response flags, one cycle behind the request
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
            err    <= 1'b0;
        end else begin
            rvalid <= rd_go;
            err    <= oob;
        end
    end

    // bank select lines up with the bank's registered data
    always_ff @(posedge clk) begin
        sel_q <= sel;
    end

    // zero data on an error response
    assign rdata = err ? '0 : bank_rdata[sel_q];

    // decoder never flags a read and a range error together
    a_resp_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(rvalid && err)
    ) else $error("rvalid and err high together");

endmodule

//--- design/mem_bank.sv
`timescale 1ns/1ps

module mem_bank (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::mem_req_t bank_req,
    output mem_pkg::data_t    rdata
);

    // contents survive reset
    mem_pkg::data_t mem [mem_pkg::BANK_WORDS];

    logic wr_en;
    logic rd_en;

    assign wr_en = bank_req.req && bank_req.we;
    assign rd_en = bank_req.req && !bank_req.we;

    // byte lane writes, disabled lanes keep old bytes
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < mem_pkg::STRB_W; b++) begin
                if (bank_req.be[b]) begin
                    mem[bank_req.word][8*b +: 8] <= bank_req.wdata[8*b +: 8];
                end
            end
        end
    end

    // read port, holds last word between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[bank_req.word];
        end
    end

    // decoder gating by ready must keep the bank idle in reset
    a_no_req_in_reset: assert property (
        @(posedge clk) rst |-> !bank_req.req
    ) else $error("bank request during reset");

endmodule

//--- design/bank_decoder.sv
`timescale 1ns/1ps

module bank_decoder (
    input  logic               ready,
    input  logic               req,
    input  mem_pkg::addr_t     addr,
    input  logic               we,
    input  mem_pkg::strb_t     be,
    input  mem_pkg::data_t     wdata,
    output mem_pkg::mem_req_t  bank_req [mem_pkg::NUM_BANKS],
    output logic               rd_go,
    output mem_pkg::bank_idx_t sel,
    output logic               oob
);

    logic                          accept;
    logic                          out_of_range;
    mem_pkg::word_idx_t            word;
    mem_pkg::bank_idx_t            bank;
    logic [mem_pkg::NUM_BANKS-1:0] hit;

    // split the byte address, low offset bits dropped
    assign word         = addr[mem_pkg::WORD_LSB +: mem_pkg::WORD_IDX_W];
    assign bank         = addr[mem_pkg::BANK_LSB +: mem_pkg::BANK_IDX_W];
    assign out_of_range = |addr[mem_pkg::ADDR_W-1:mem_pkg::OOB_LSB];

    // requests only count once the subsystem is ready
    assign accept = ready && req;

    // fan out, only the addressed bank sees req
    for (genvar i = 0; i < mem_pkg::NUM_BANKS; i++) begin : g_fanout
        assign hit[i] = accept && !out_of_range &&
                        (bank == mem_pkg::bank_idx_t'(i));

        assign bank_req[i].req   = hit[i];
        assign bank_req[i].we    = we;
        assign bank_req[i].be    = be;
        assign bank_req[i].word  = word;
        assign bank_req[i].wdata = wdata;
    end

    // response side info for the read mux
    assign rd_go = accept && !out_of_range && !we;
    assign oob   = accept && out_of_range;
    assign sel   = bank;

endmodule

//--- design/reset_stretch.sv
`timescale 1ns/1ps

module reset_stretch (
    input  logic clk,
    input  logic rst,
    output logic rst_int,
    output logic ready
);

    mem_pkg::rst_cnt_t cnt;

    // reload while rst is high, then count down to zero
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= mem_pkg::rst_cnt_t'(mem_pkg::RST_HOLD);
            rst_int <= 1'b1;
            ready   <= 1'b0;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else begin
            // stretch over, both flip on the same edge
            rst_int <= 1'b0;
            ready   <= 1'b1;
        end
    end

    // internal reset spans RST_HOLD cycles after the first low rst sample
    a_stretch_len: assert property (
        @(posedge clk) disable iff (rst)
        $fell(rst) |-> (rst_int && !ready) [*mem_pkg::RST_HOLD + 1]
                       ##1 (!rst_int && ready)
    ) else $error("internal reset stretch has the wrong length");

endmodule

//--- design/mem_pkg.sv
package mem_pkg;

    // sizes
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int BANK_WORDS = 256;
    localparam int NUM_BANKS  = 4;
    localparam int RST_HOLD   = 16;
    localparam int ADDR_W     = 16;

    localparam int WORD_IDX_W = $clog2(BANK_WORDS);
    localparam int BANK_IDX_W = $clog2(NUM_BANKS);
    localparam int RST_CNT_W  = $clog2(RST_HOLD + 1);

    // address map: byte offset, word index, bank number, range bits
    localparam int WORD_LSB = $clog2(STRB_W);
    localparam int BANK_LSB = WORD_LSB + WORD_IDX_W;
    localparam int OOB_LSB  = BANK_LSB + BANK_IDX_W;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [STRB_W-1:0]     strb_t;
    typedef logic [WORD_IDX_W-1:0] word_idx_t;
    typedef logic [BANK_IDX_W-1:0] bank_idx_t;
    typedef logic [RST_CNT_W-1:0]  rst_cnt_t;

    // one bank's view of a request
    typedef struct packed {
        logic      req;
        logic      we;
        strb_t     be;
        word_idx_t word;
        data_t     wdata;
    } mem_req_t;

endpackage
